// File: design/mem_unit_pkg.sv
package mem_unit_pkg;

  // one bus word, used for both addresses and data beats
  typedef logic [31:0] word_t;

  // immediate offset of a load or store, sign extended before the add
  typedef logic [11:0] offset_t;

  // value of the outstanding-read, outstanding-write and write-balance counters
  typedef logic [3:0] count_t;

  // queue entry as it sits in the request and response FIFOs
  typedef logic [64:0] txn_t;

  localparam int TXN_WRITE_BIT = 64;
  localparam int TXN_ADDR_LSB = 32;
  localparam int TXN_DATA_LSB = 0;

  // entry handed to commit, with the read data in the low word
  typedef logic [33:0] commit_t;

  localparam int COMMIT_WRITE_BIT = 33;
  localparam int COMMIT_ERROR_BIT = 32;

  // both queues get this depth unless the top says otherwise
  localparam int IO_FIFO_DEPTH = 8;

  // a counter never goes past this, so a 4-bit count_t always fits
  localparam int PENDING_MAX = 7;

  // bus response code on R and B
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY = 2'b00;

  // write launch; AW and W can be accepted in either order
  typedef enum logic [1:0] {
    REQ_IDLE,
    REQ_WAIT_AW,
    REQ_WAIT_W
  } req_state_t;

endpackage

// File: design/mem_fifo.sv
`timescale 1ns/10ps

module mem_fifo #(
  parameter int DEPTH = mem_unit_pkg::IO_FIFO_DEPTH
) (
  input  logic               clk_core,
  input  logic               rst_core_n,
  input  logic               flush_i,
  input  mem_unit_pkg::txn_t in_i,
  input  logic               valid_i,
  output logic               ready_o,
  output mem_unit_pkg::txn_t out_o,
  output logic               valid_o,
  input  logic               ready_i
);

  typedef logic [$clog2(DEPTH)-1:0] ptr_t;
  typedef logic [$clog2(DEPTH + 1)-1:0] cnt_t;

  mem_unit_pkg::txn_t mem_q [DEPTH];
  ptr_t rd_ptr_q;
  ptr_t wr_ptr_q;
  cnt_t count_q;
  logic push;
  logic pop;

  // the occupancy count tells full from empty when the pointers meet
  assign ready_o = (count_q != cnt_t'(DEPTH));
  assign valid_o = (count_q != '0);
  assign out_o = mem_q[rd_ptr_q];

  assign push = valid_i & ready_o;
  assign pop = valid_o & ready_i;

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q <= '0;
    end else begin
      // pointers wrap by compare, so the depth need not be a power of two
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // a push and a pop in the same cycle leave the count alone
      count_q <= count_q + cnt_t'(push) - cnt_t'(pop);
    end
  end

  always_ff @(posedge clk_core) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_i;
    end
  end

endmodule

// File: design/mem_address_stage.sv
`timescale 1ns/10ps

module mem_address_stage (
  input  logic                  clk_core,
  input  logic                  rst_core_n,
  input  logic                  flush_i,
  input  logic                  valid_i,
  input  logic                  is_write_i,
  input  mem_unit_pkg::word_t   base_i,
  input  mem_unit_pkg::offset_t offset_i,
  input  mem_unit_pkg::word_t   wdata_i,
  input  logic                  req_ready_i,
  input  logic                  resp_ready_i,
  output logic                  ready_o,
  output mem_unit_pkg::txn_t    txn_o,
  output logic                  req_valid_o,
  output logic                  resp_valid_o
);

  logic req_pending_q;
  logic resp_pending_q;
  mem_unit_pkg::word_t addr;

  // effective address is base plus the sign-extended immediate
  assign addr = base_i + {{20{offset_i[11]}}, offset_i};

  // the held entry blocks new work only while one of the queues refuses it
  assign ready_o = ~(req_pending_q & ~req_ready_i) & ~(resp_pending_q & ~resp_ready_i);

  assign req_valid_o = req_pending_q;
  assign resp_valid_o = resp_pending_q;

  // each queue's push is tracked on its own, so the one that already took
  // the entry is not offered it a second time
  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      req_pending_q <= 1'b0;
      resp_pending_q <= 1'b0;
    end else if (flush_i) begin
      req_pending_q <= 1'b0;
      resp_pending_q <= 1'b0;
    end else if (ready_o) begin
      req_pending_q <= valid_i;
      resp_pending_q <= valid_i;
    end else begin
      req_pending_q <= req_pending_q & ~req_ready_i;
      resp_pending_q <= resp_pending_q & ~resp_ready_i;
    end
  end

  always_ff @(posedge clk_core) begin
    if (ready_o && valid_i) begin
      txn_o[mem_unit_pkg::TXN_WRITE_BIT] <= is_write_i;
      txn_o[mem_unit_pkg::TXN_ADDR_LSB +: 32] <= addr;
      txn_o[mem_unit_pkg::TXN_DATA_LSB +: 32] <= wdata_i;
    end
  end

endmodule

// File: design/mem_request_stage.sv
`timescale 1ns/10ps

module mem_request_stage (
  input  logic                 clk_core,
  input  logic                 rst_core_n,
  input  logic                 flush_i,
  input  mem_unit_pkg::txn_t   txn_i,
  input  logic                 valid_i,
  output logic                 ready_o,
  input  mem_unit_pkg::count_t pending_reads_i,
  input  mem_unit_pkg::count_t pending_writes_i,
  input  mem_unit_pkg::count_t write_balance_i,
  output logic                 pending_reads_up_o,
  output logic                 pending_writes_up_o,
  output logic                 write_balance_down_o,
  output logic                 ar_valid_o,
  input  logic                 ar_ready_i,
  output mem_unit_pkg::word_t  ar_addr_o,
  output logic                 aw_valid_o,
  input  logic                 aw_ready_i,
  output mem_unit_pkg::word_t  aw_addr_o,
  output logic                 w_valid_o,
  input  logic                 w_ready_i,
  output mem_unit_pkg::word_t  w_data_o
);

  mem_unit_pkg::req_state_t state_q;
  mem_unit_pkg::req_state_t state_d;
  logic is_write;
  logic can_read;
  logic can_write;

  assign is_write = txn_i[mem_unit_pkg::TXN_WRITE_BIT];
  assign ar_addr_o = txn_i[mem_unit_pkg::TXN_ADDR_LSB +: 32];
  assign aw_addr_o = txn_i[mem_unit_pkg::TXN_ADDR_LSB +: 32];
  assign w_data_o = txn_i[mem_unit_pkg::TXN_DATA_LSB +: 32];

  // the bus gives no order between reads and writes, so a read waits out
  // every write and a write waits out every read
  assign can_read = valid_i & ~is_write & (pending_writes_i == '0) &
                    (pending_reads_i < mem_unit_pkg::count_t'(mem_unit_pkg::PENDING_MAX));

  // a write also needs a grant from commit still unspent in the balance
  assign can_write = valid_i & is_write & (pending_reads_i == '0) &
                     (write_balance_i != '0) &
                     (pending_writes_i < mem_unit_pkg::count_t'(mem_unit_pkg::PENDING_MAX));

  // only this stage raises the counters that gate a launch, so a raised
  // valid cannot fall back before its handshake
  always_comb begin
    state_d = state_q;
    ready_o = 1'b0;
    ar_valid_o = 1'b0;
    aw_valid_o = 1'b0;
    w_valid_o = 1'b0;
    pending_reads_up_o = 1'b0;
    pending_writes_up_o = 1'b0;
    write_balance_down_o = 1'b0;
    case (state_q)
      mem_unit_pkg::REQ_IDLE: begin
        ar_valid_o = can_read;
        aw_valid_o = can_write;
        w_valid_o = can_write;
        pending_reads_up_o = can_read & ar_ready_i;
        ready_o = (can_read & ar_ready_i) | (can_write & aw_ready_i & w_ready_i);
        // the write counts as launched once either channel has taken it
        if (can_write && (aw_ready_i || w_ready_i)) begin
          pending_writes_up_o = 1'b1;
          write_balance_down_o = 1'b1;
          if (!aw_ready_i) begin
            state_d = mem_unit_pkg::REQ_WAIT_AW;
          end else if (!w_ready_i) begin
            state_d = mem_unit_pkg::REQ_WAIT_W;
          end
        end
      end
      mem_unit_pkg::REQ_WAIT_AW: begin
        aw_valid_o = 1'b1;
        if (aw_ready_i) begin
          ready_o = 1'b1;
          state_d = mem_unit_pkg::REQ_IDLE;
        end
      end
      default: begin
        w_valid_o = 1'b1;
        if (w_ready_i) begin
          ready_o = 1'b1;
          state_d = mem_unit_pkg::REQ_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      state_q <= mem_unit_pkg::REQ_IDLE;
    end else if (flush_i) begin
      state_q <= mem_unit_pkg::REQ_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: design/mem_response_stage.sv
`timescale 1ns/10ps

module mem_response_stage (
  input  logic                  clk_core,
  input  logic                  rst_core_n,
  input  logic                  flush_i,
  input  mem_unit_pkg::txn_t    txn_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  input  logic                  out_ready_i,
  output logic                  out_valid_o,
  output mem_unit_pkg::commit_t out_o,
  input  logic                  r_valid_i,
  output logic                  r_ready_o,
  input  mem_unit_pkg::word_t   r_data_i,
  input  mem_unit_pkg::resp_t   r_resp_i,
  input  logic                  b_valid_i,
  output logic                  b_ready_o,
  input  mem_unit_pkg::resp_t   b_resp_i,
  output logic                  pending_reads_down_o,
  output logic                  pending_writes_down_o
);

  logic is_write;
  logic b_done_q;

  assign is_write = txn_i[mem_unit_pkg::TXN_WRITE_BIT];

  // reads launch in queue order, so an R beat always belongs to the head
  assign r_ready_o = valid_i & ~is_write & out_ready_i;
  assign pending_reads_down_o = r_valid_i & r_ready_o;

  // writes go to commit at once, which grants them back through the balance
  assign out_valid_o = valid_i & (is_write | r_valid_i);
  assign ready_o = out_valid_o & out_ready_i;

  always_comb begin
    out_o = '0;
    out_o[mem_unit_pkg::COMMIT_WRITE_BIT] = is_write;
    if (!is_write) begin
      out_o[mem_unit_pkg::COMMIT_ERROR_BIT] = (r_resp_i != mem_unit_pkg::RESP_OKAY);
      out_o[mem_unit_pkg::COMMIT_ERROR_BIT-1:0] = r_data_i;
    end
  end

  // B beats are always taken; b_resp_i is not reported anywhere because
  // commit already retired the write before it reached the bus
  assign b_ready_o = 1'b1;

  // the write count falls one cycle after the B handshake
  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      b_done_q <= 1'b0;
    end else if (flush_i) begin
      b_done_q <= 1'b0;
    end else begin
      b_done_q <= b_valid_i & b_ready_o;
    end
  end

  assign pending_writes_down_o = b_done_q;

endmodule

// File: design/mem_counter.sv
`timescale 1ns/10ps

module mem_counter (
  input  logic                 clk_core,
  input  logic                 rst_core_n,
  input  logic                 flush_i,
  input  logic                 up_i,
  input  logic                 down_i,
  output mem_unit_pkg::count_t value_o
);

  // an up and a down in the same cycle cancel out
  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      value_o <= '0;
    end else if (flush_i) begin
      value_o <= '0;
    end else if (up_i && !down_i) begin
      value_o <= value_o + 1'b1;
    end else if (down_i && !up_i) begin
      value_o <= value_o - 1'b1;
    end
  end

endmodule

// File: design/mem_skid_buffer.sv
`timescale 1ns/10ps

module mem_skid_buffer (
  input  logic                  clk_core,
  input  logic                  rst_core_n,
  input  logic                  flush_i,
  input  mem_unit_pkg::commit_t in_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  output mem_unit_pkg::commit_t out_o,
  output logic                  valid_o,
  input  logic                  ready_i
);

  mem_unit_pkg::commit_t main_q;
  mem_unit_pkg::commit_t skid_q;
  logic main_valid_q;
  logic skid_valid_q;
  logic ready_q;
  logic accept;
  logic skid_valid_d;

  // with the main register empty the input passes straight through
  assign valid_o = main_valid_q | valid_i;
  assign out_o = main_valid_q ? main_q : in_i;

  assign ready_o = ready_q;
  assign accept = valid_i & ready_q;

  // the skid register fills only when main is stalled and a new entry lands
  assign skid_valid_d = main_valid_q & ~ready_i & (skid_valid_q | accept);

  // ready is taken from a flop, so ready_i never reaches ready_o in the
  // same cycle; a free skid register means any accepted entry has a place
  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
      ready_q <= 1'b1;
    end else if (flush_i) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
      ready_q <= 1'b1;
    end else begin
      if (main_valid_q) begin
        main_valid_q <= ~ready_i | skid_valid_q | accept;
      end else begin
        main_valid_q <= accept & ~ready_i;
      end
      skid_valid_q <= skid_valid_d;
      ready_q <= ~skid_valid_d;
    end
  end

  always_ff @(posedge clk_core) begin
    if (main_valid_q && ready_i) begin
      main_q <= skid_valid_q ? skid_q : in_i;
    end else if (!main_valid_q) begin
      main_q <= in_i;
    end
    if (main_valid_q && !ready_i && accept) begin
      skid_q <= in_i;
    end
  end

endmodule

// File: design/mem_unit.sv
`timescale 1ns/10ps

module mem_unit (
  input  logic                  clk_core,
  input  logic                  rst_core_n,
  input  logic                  valid_i,
  output logic                  ready_o,
  input  logic                  is_write_i,
  input  mem_unit_pkg::word_t   base_i,
  input  mem_unit_pkg::offset_t offset_i,
  input  mem_unit_pkg::word_t   wdata_i,
  output logic                  valid_o,
  input  logic                  ready_i,
  output mem_unit_pkg::commit_t result_o,
  input  logic                  commit_mem_i,
  input  logic                  flush_req_i,
  output logic                  flush_ack_o,
  output logic                  ar_valid_o,
  input  logic                  ar_ready_i,
  output mem_unit_pkg::word_t   ar_addr_o,
  output logic                  aw_valid_o,
  input  logic                  aw_ready_i,
  output mem_unit_pkg::word_t   aw_addr_o,
  output logic                  w_valid_o,
  input  logic                  w_ready_i,
  output mem_unit_pkg::word_t   w_data_o,
  input  logic                  r_valid_i,
  output logic                  r_ready_o,
  input  mem_unit_pkg::word_t   r_data_i,
  input  mem_unit_pkg::resp_t   r_resp_i,
  input  logic                  b_valid_i,
  output logic                  b_ready_o,
  input  mem_unit_pkg::resp_t   b_resp_i
);

  mem_unit_pkg::txn_t txn;
  mem_unit_pkg::txn_t req_head;
  mem_unit_pkg::txn_t resp_head;
  mem_unit_pkg::commit_t resp_out;
  mem_unit_pkg::count_t pending_reads;
  mem_unit_pkg::count_t pending_writes;
  mem_unit_pkg::count_t write_balance;
  logic req_in_valid;
  logic req_in_ready;
  logic req_out_valid;
  logic req_out_ready;
  logic resp_in_valid;
  logic resp_in_ready;
  logic resp_out_valid;
  logic resp_out_ready;
  logic skid_valid;
  logic skid_ready;
  logic pending_reads_up;
  logic pending_reads_down;
  logic pending_writes_up;
  logic pending_writes_down;
  logic write_balance_down;
  logic can_flush;

  // every launched access has come back and every grant has been spent
  assign can_flush = (pending_reads == '0) & (pending_writes == '0) & (write_balance == '0);

  mem_address_stage i_address_stage (
    .clk_core,
    .rst_core_n,
    .flush_i      (flush_ack_o),
    .valid_i,
    .is_write_i,
    .base_i,
    .offset_i,
    .wdata_i,
    .req_ready_i  (req_in_ready),
    .resp_ready_i (resp_in_ready),
    .ready_o,
    .txn_o        (txn),
    .req_valid_o  (req_in_valid),
    .resp_valid_o (resp_in_valid)
  );

  mem_fifo #(
    .DEPTH(mem_unit_pkg::IO_FIFO_DEPTH)
  ) i_request_fifo (
    .clk_core,
    .rst_core_n,
    .flush_i (flush_ack_o),
    .in_i    (txn),
    .valid_i (req_in_valid),
    .ready_o (req_in_ready),
    .out_o   (req_head),
    .valid_o (req_out_valid),
    .ready_i (req_out_ready)
  );

  mem_request_stage i_request_stage (
    .clk_core,
    .rst_core_n,
    .flush_i              (flush_ack_o),
    .txn_i                (req_head),
    .valid_i              (req_out_valid),
    .ready_o              (req_out_ready),
    .pending_reads_i      (pending_reads),
    .pending_writes_i     (pending_writes),
    .write_balance_i      (write_balance),
    .pending_reads_up_o   (pending_reads_up),
    .pending_writes_up_o  (pending_writes_up),
    .write_balance_down_o (write_balance_down),
    .ar_valid_o,
    .ar_ready_i,
    .ar_addr_o,
    .aw_valid_o,
    .aw_ready_i,
    .aw_addr_o,
    .w_valid_o,
    .w_ready_i,
    .w_data_o
  );

  mem_fifo #(
    .DEPTH(mem_unit_pkg::IO_FIFO_DEPTH)
  ) i_response_fifo (
    .clk_core,
    .rst_core_n,
    .flush_i (flush_ack_o),
    .in_i    (txn),
    .valid_i (resp_in_valid),
    .ready_o (resp_in_ready),
    .out_o   (resp_head),
    .valid_o (resp_out_valid),
    .ready_i (resp_out_ready)
  );

  mem_response_stage i_response_stage (
    .clk_core,
    .rst_core_n,
    .flush_i               (flush_ack_o),
    .txn_i                 (resp_head),
    .valid_i               (resp_out_valid),
    .ready_o               (resp_out_ready),
    .out_ready_i           (skid_ready),
    .out_valid_o           (skid_valid),
    .out_o                 (resp_out),
    .r_valid_i,
    .r_ready_o,
    .r_data_i,
    .r_resp_i,
    .b_valid_i,
    .b_ready_o,
    .b_resp_i,
    .pending_reads_down_o  (pending_reads_down),
    .pending_writes_down_o (pending_writes_down)
  );

  mem_skid_buffer i_skid_buffer (
    .clk_core,
    .rst_core_n,
    .flush_i (flush_ack_o),
    .in_i    (resp_out),
    .valid_i (skid_valid),
    .ready_o (skid_ready),
    .out_o   (result_o),
    .valid_o,
    .ready_i
  );

  // reads on AR not yet answered on R
  mem_counter i_pending_reads (
    .clk_core,
    .rst_core_n,
    .flush_i (flush_ack_o),
    .up_i    (pending_reads_up),
    .down_i  (pending_reads_down),
    .value_o (pending_reads)
  );

  // writes on AW or W not yet answered on B
  mem_counter i_pending_writes (
    .clk_core,
    .rst_core_n,
    .flush_i (flush_ack_o),
    .up_i    (pending_writes_up),
    .down_i  (pending_writes_down),
    .value_o (pending_writes)
  );

  // writes granted by commit but not yet started on the bus
  mem_counter i_write_balance (
    .clk_core,
    .rst_core_n,
    .flush_i (flush_ack_o),
    .up_i    (commit_mem_i),
    .down_i  (write_balance_down),
    .value_o (write_balance)
  );

  // the acknowledge comes out of reset high and then doubles as the flush
  // that clears the stages, queues, counters and skid buffer
  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      flush_ack_o <= 1'b1;
    end else begin
      flush_ack_o <= flush_req_i & can_flush;
    end
  end

endmodule

// File: test/mem_unit_tb.sv
`timescale 1ns/10ps

module mem_unit_tb;

  localparam int MAX_OPS = 64;
  localparam int FIELDS = 5;
  localparam logic [33:0] NO_ENTRY = '1;
  localparam mem_unit_pkg::resp_t RESP_SLVERR = 2'b10;

  logic clk_core = 1'b0;
  logic rst_core_n;
  logic valid_i;
  logic ready_o;
  logic is_write_i;
  mem_unit_pkg::word_t base_i;
  mem_unit_pkg::offset_t offset_i;
  mem_unit_pkg::word_t wdata_i;
  logic valid_o;
  logic ready_i = 1'b0;
  mem_unit_pkg::commit_t result_o;
  logic commit_mem_i = 1'b0;
  logic flush_req_i;
  logic flush_ack_o;
  logic ar_valid_o;
  logic ar_ready_i = 1'b0;
  mem_unit_pkg::word_t ar_addr_o;
  logic aw_valid_o;
  logic aw_ready_i = 1'b0;
  mem_unit_pkg::word_t aw_addr_o;
  logic w_valid_o;
  logic w_ready_i = 1'b0;
  mem_unit_pkg::word_t w_data_o;
  logic r_valid_i = 1'b0;
  logic r_ready_o;
  mem_unit_pkg::word_t r_data_i = '0;
  mem_unit_pkg::resp_t r_resp_i = '0;
  logic b_valid_i = 1'b0;
  logic b_ready_o;
  mem_unit_pkg::resp_t b_resp_i = '0;

  // raw data file words, five per operation
  logic [33:0] testdata [FIELDS*MAX_OPS];
  logic op_write [MAX_OPS];
  mem_unit_pkg::word_t op_base [MAX_OPS];
  mem_unit_pkg::offset_t op_offset [MAX_OPS];
  mem_unit_pkg::word_t op_wdata [MAX_OPS];
  mem_unit_pkg::commit_t op_expect [MAX_OPS];
  mem_unit_pkg::word_t rd_addr_exp [MAX_OPS];
  mem_unit_pkg::word_t wr_addr_exp [MAX_OPS];
  mem_unit_pkg::word_t wr_data_exp [MAX_OPS];
  int n_ops = 0;
  int n_reads = 0;
  int n_writes = 0;
  bit loaded = 1'b0;

  // memory model holds only the words that were written
  mem_unit_pkg::word_t mem_model [mem_unit_pkg::word_t];
  mem_unit_pkg::word_t r_data_q [$];
  mem_unit_pkg::resp_t r_resp_q [$];
  mem_unit_pkg::word_t aw_addr_q [$];
  mem_unit_pkg::word_t w_data_q [$];
  mem_unit_pkg::resp_t b_resp_q [$];
  int ar_gap = 0;
  int aw_gap = 0;
  int w_gap = 0;
  int r_gap = 0;
  int b_gap = 0;

  // handshake counts seen on the bus and at commit
  int ar_cnt = 0;
  int r_cnt = 0;
  int aw_cnt = 0;
  int w_cnt = 0;
  int b_cnt = 0;
  int grants = 0;
  int commit_idx = 0;
  int value_errors = 0;
  int protocol_errors = 0;

  mem_unit i_dut (.*);

  always #4 clk_core = ~clk_core;

  // the immediate is signed, so it is widened to a signed integer before the add
  function automatic mem_unit_pkg::word_t effective_addr(input mem_unit_pkg::word_t base,
                                                         input mem_unit_pkg::offset_t offset);
    int offset_value;
    offset_value = $signed(offset);
    return base + mem_unit_pkg::word_t'(offset_value);
  endfunction

  // untouched word address A reads back as A xor 5A5A0000
  function automatic mem_unit_pkg::word_t mem_read(input mem_unit_pkg::word_t addr);
    mem_unit_pkg::word_t wa;
    wa = {2'b00, addr[31:2]};
    if (mem_model.exists(wa)) begin
      return mem_model[wa];
    end
    return wa ^ 32'h5A5A0000;
  endfunction

  // a write counts as open from its first accepted channel until its B beat
  function automatic int writes_open();
    return ((aw_cnt > w_cnt) ? aw_cnt : w_cnt) - b_cnt;
  endfunction

  function automatic int reads_open();
    return ar_cnt - r_cnt;
  endfunction

  task automatic check_commit(input string name, input mem_unit_pkg::commit_t expected,
                              input mem_unit_pkg::commit_t actual);
    if (actual !== expected) begin
      value_errors++;
      $display("Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_word(input string name, input mem_unit_pkg::word_t expected,
                            input mem_unit_pkg::word_t actual);
    if (actual !== expected) begin
      value_errors++;
      $display("Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic protocol_problem(input string msg);
    protocol_errors++;
    $display("%s", msg);
  endtask

  task automatic report_and_finish(input bit timed_out);
    $display("error count: %0d value, %0d protocol, %0d timeout",
             value_errors, protocol_errors, timed_out);
    if (timed_out || value_errors != 0 || protocol_errors != 0) begin
      $display("STATUS: FAIL");
    end else begin
      $display("STATUS: PASS");
    end
    $finish;
  endtask

  // bus slave, sampling at the edge and driving 1 ns later
  always @(posedge clk_core) begin : bus_model
    mem_unit_pkg::word_t addr;
    mem_unit_pkg::word_t data;
    if (rst_core_n) begin
      // ordering rules use the counts left by earlier edges
      if (ar_valid_o && writes_open() != 0) begin
        protocol_problem("read address raised while a write response is outstanding");
      end
      if ((aw_valid_o || w_valid_o) && reads_open() != 0) begin
        protocol_problem("write raised while a read response is outstanding");
      end
      if (flush_ack_o && (writes_open() != 0 || reads_open() != 0)) begin
        protocol_problem("flush acknowledged while bus responses are outstanding");
      end
      if (ar_valid_o && ar_ready_i) begin
        if (ar_cnt < n_reads) begin
          check_word($sformatf("read address %0d", ar_cnt), rd_addr_exp[ar_cnt], ar_addr_o);
        end else begin
          protocol_problem("more reads issued on the bus than the test list holds");
        end
        // bit 31 marks an address range that answers with an error
        r_data_q.push_back(ar_addr_o[31] ? '0 : mem_read(ar_addr_o));
        r_resp_q.push_back(ar_addr_o[31] ? RESP_SLVERR : mem_unit_pkg::RESP_OKAY);
        ar_cnt++;
        ar_gap = $urandom % 4;
      end else if (ar_valid_o && ar_gap != 0) begin
        ar_gap--;
      end
      if (aw_valid_o && aw_ready_i) begin
        if (aw_cnt >= grants) begin
          protocol_problem("write address launched without a commit grant");
        end
        if (aw_cnt < n_writes) begin
          check_word($sformatf("write address %0d", aw_cnt), wr_addr_exp[aw_cnt], aw_addr_o);
        end else begin
          protocol_problem("more write addresses issued than the test list holds");
        end
        aw_addr_q.push_back(aw_addr_o);
        aw_cnt++;
        aw_gap = $urandom % 4;
      end else if (aw_valid_o && aw_gap != 0) begin
        aw_gap--;
      end
      if (w_valid_o && w_ready_i) begin
        if (w_cnt >= grants) begin
          protocol_problem("write data launched without a commit grant");
        end
        if (w_cnt < n_writes) begin
          check_word($sformatf("write data %0d", w_cnt), wr_data_exp[w_cnt], w_data_o);
        end else begin
          protocol_problem("more write data beats issued than the test list holds");
        end
        w_data_q.push_back(w_data_o);
        w_cnt++;
        w_gap = $urandom % 4;
      end else if (w_valid_o && w_gap != 0) begin
        w_gap--;
      end
      // a write lands once both its address and its data have arrived
      if (aw_addr_q.size() != 0 && w_data_q.size() != 0) begin
        addr = aw_addr_q.pop_front();
        data = w_data_q.pop_front();
        if (!addr[31]) begin
          mem_model[{2'b00, addr[31:2]}] = data;
        end
        b_resp_q.push_back(addr[31] ? RESP_SLVERR : mem_unit_pkg::RESP_OKAY);
      end
      if (r_valid_i && r_ready_o) begin
        void'(r_data_q.pop_front());
        void'(r_resp_q.pop_front());
        r_cnt++;
        r_gap = $urandom % 4;
      end else if (r_gap != 0) begin
        r_gap--;
      end
      if (b_valid_i && b_ready_o) begin
        void'(b_resp_q.pop_front());
        b_cnt++;
        b_gap = $urandom % 4;
      end else if (b_gap != 0) begin
        b_gap--;
      end
      if (commit_mem_i) begin
        grants++;
      end
    end
    #1;
    ar_ready_i = (ar_gap == 0);
    aw_ready_i = (aw_gap == 0);
    w_ready_i = (w_gap == 0);
    r_valid_i = (r_data_q.size() != 0) && (r_gap == 0);
    r_data_i = (r_data_q.size() != 0) ? r_data_q[0] : '0;
    r_resp_i = (r_resp_q.size() != 0) ? r_resp_q[0] : mem_unit_pkg::RESP_OKAY;
    b_valid_i = (b_resp_q.size() != 0) && (b_gap == 0);
    b_resp_i = (b_resp_q.size() != 0) ? b_resp_q[0] : mem_unit_pkg::RESP_OKAY;
  end

  // commit side takes results with random stalls and grants each write
  // one cycle after it was taken
  always @(posedge clk_core) begin : commit_model
    logic grant_next;
    grant_next = 1'b0;
    if (rst_core_n && valid_o && ready_i) begin
      if (commit_idx < n_ops) begin
        check_commit($sformatf("commit %0d", commit_idx), op_expect[commit_idx], result_o);
      end else begin
        protocol_problem("commit entry delivered beyond the end of the test list");
      end
      grant_next = result_o[mem_unit_pkg::COMMIT_WRITE_BIT];
      commit_idx++;
    end
    #1;
    commit_mem_i = grant_next;
    ready_i = ($urandom % 4) != 0;
  end

  initial begin : watchdog
    int limit;
    wait (loaded);
    limit = n_ops * 40 + 200;
    repeat (limit) @(posedge clk_core);
    $display("timeout: the run did not complete within %0d cycles", limit);
    report_and_finish(1'b1);
  end

  initial begin : main
    int i;
    int waited;
    void'($urandom(10));
    rst_core_n = 1'b0;
    valid_i = 1'b0;
    is_write_i = 1'b0;
    base_i = '0;
    offset_i = '0;
    wdata_i = '0;
    flush_req_i = 1'b0;

    for (i = 0; i < FIELDS * MAX_OPS; i++) begin
      testdata[i] = NO_ENTRY;
    end
    $readmemh("test/mem_unit_testdata.txt", testdata);
    while (n_ops < MAX_OPS && testdata[FIELDS*n_ops] != NO_ENTRY) begin
      op_write[n_ops] = testdata[FIELDS*n_ops][0];
      op_base[n_ops] = testdata[FIELDS*n_ops+1][31:0];
      op_offset[n_ops] = testdata[FIELDS*n_ops+2][11:0];
      op_wdata[n_ops] = testdata[FIELDS*n_ops+3][31:0];
      op_expect[n_ops] = testdata[FIELDS*n_ops+4];
      if (op_write[n_ops]) begin
        wr_addr_exp[n_writes] = effective_addr(op_base[n_ops], op_offset[n_ops]);
        wr_data_exp[n_writes] = op_wdata[n_ops];
        n_writes++;
      end else begin
        rd_addr_exp[n_reads] = effective_addr(op_base[n_ops], op_offset[n_ops]);
        n_reads++;
      end
      n_ops++;
    end
    if (n_ops == 0) begin
      protocol_problem("no operations could be read from the test data file");
    end
    loaded = 1'b1;

    // reset values are checked near the end of the reset pulse
    repeat (9) @(posedge clk_core);
    if (flush_ack_o !== 1'b1) begin
      protocol_problem("flush acknowledge is not high in reset");
    end
    if (valid_o !== 1'b0 || ar_valid_o !== 1'b0 || aw_valid_o !== 1'b0 || w_valid_o !== 1'b0) begin
      protocol_problem("a valid output is not low in reset");
    end
    if (b_ready_o !== 1'b1) begin
      protocol_problem("write response ready is not high in reset");
    end
    @(posedge clk_core);
    #1 rst_core_n = 1'b1;

    // the unit stays cleared while the reset-time acknowledge is high
    @(posedge clk_core);
    while (flush_ack_o) begin
      @(posedge clk_core);
    end

    for (i = 0; i < n_ops; i++) begin
      if ($urandom % 4 == 0) begin
        #1 valid_i = 1'b0;
        @(posedge clk_core);
      end
      #1;
      valid_i = 1'b1;
      is_write_i = op_write[i];
      base_i = op_base[i];
      offset_i = op_offset[i];
      wdata_i = op_wdata[i];
      @(posedge clk_core);
      while (!ready_o) begin
        @(posedge clk_core);
      end
    end
    #1 valid_i = 1'b0;

    // the grant for a final write goes out one cycle after its commit
    wait (commit_idx >= n_ops);
    @(posedge clk_core);

    // late B beats may still be in flight when the last result commits
    #1 flush_req_i = 1'b1;
    waited = 0;
    @(posedge clk_core);
    while (!flush_ack_o && waited < 100) begin
      waited++;
      @(posedge clk_core);
    end
    if (!flush_ack_o) begin
      protocol_problem("flush was not acknowledged after all bus responses returned");
    end
    #1 flush_req_i = 1'b0;
    repeat (10) @(posedge clk_core);

    if (commit_idx != n_ops) begin
      protocol_problem("number of commit entries differs from the test list");
    end
    if (ar_cnt != n_reads || r_cnt != n_reads) begin
      protocol_problem("number of read transfers differs from the reads in the test list");
    end
    if (aw_cnt != n_writes || w_cnt != n_writes || b_cnt != n_writes) begin
      protocol_problem("number of write transfers differs from the writes in the test list");
    end
    if (grants != n_writes) begin
      protocol_problem("number of commit grants differs from the writes in the test list");
    end
    report_and_finish(1'b0);
  end

endmodule

// File: test/mem_unit_testdata.txt
// columns: op (0 read, 1 write), base, offset, wdata, expected commit entry
// commit entry is {write, error, read data} in hex; every write commits as 200000000
0 00000100 000 00000000 05a5a0040
0 00000200 ffc 00000000 05a5a007f
1 00000100 010 deadbeef 200000000
0 00000100 010 00000000 0deadbeef
1 00000300 7fc 12345678 200000000
1 00000400 800 cafef00d 200000000
0 00000b00 ffc 00000000 012345678
0 80000000 020 00000000 100000000
0 00001000 000 00000000 05a5a0400
1 00001000 004 0badc0de 200000000
1 00001000 008 55aa55aa 200000000
0 00001000 004 00000000 00badc0de
0 00001000 008 00000000 055aa55aa
0 fffffc00 000 00000000 100000000
0 00001000 00c 00000000 05a5a0403
0 00000100 000 00000000 05a5a0040
1 00002000 000 a5a5a5a5 200000000
1 00002000 004 01020304 200000000
0 00002000 000 00000000 0a5a5a5a5
0 00002008 ffc 00000000 001020304

// File: list.f
design/mem_unit_pkg.sv
design/mem_fifo.sv
design/mem_address_stage.sv
design/mem_request_stage.sv
design/mem_response_stage.sv
design/mem_counter.sv
design/mem_skid_buffer.sv
design/mem_unit.sv
test/mem_unit_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
LINTFLAGS := --lint-only -Wall --timing
TOP       := mem_unit_tb
FILELIST  := list.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "STATUS: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
